// File: common/ls_pkg.sv
`default_nettype none

package ls_pkg;

	// datapath and address width
	localparam int xlen = 32;

	// I-type and S-type immediate width
	localparam int imm_width = 12;

	// destination tag of a memory op
	localparam int tag_width = 6;

	// store queue geometry
	localparam int sq_depth = 8;
	localparam int sq_idx_width = 3;

	// data memory geometry in words
	localparam int mem_words = 256;
	localparam int mem_idx_width = 8;

	// word index sits at address bits 9:2
	// bits above that alias, bits 1:0 are dropped

	// widen a 12-bit immediate to the full datapath width
	function automatic logic [xlen-1:0] sign_extend_imm(
		input logic [imm_width-1:0] imm
	);
		logic sign_bit;
		logic [xlen-1:0] wide;
		sign_bit = imm[imm_width-1];
		wide = {{(xlen - imm_width){sign_bit}}, imm};
		return wide;
	endfunction

endpackage

`default_nettype wire

// File: logic/ls_issue_slot.sv
`timescale 1ns/1ps
`default_nettype none

module ls_issue_slot (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          issue_valid,
	input  logic                          issue_is_store,
	input  logic [ls_pkg::xlen-1:0]       issue_base,
	input  logic [ls_pkg::imm_width-1:0]  issue_imm,
	input  logic [ls_pkg::xlen-1:0]       issue_store_data,
	input  logic [ls_pkg::tag_width-1:0]  issue_tag,
	input  logic                          sq_full,
	input  logic                          squash,
	output logic                          issue_ready,
	output logic                          release_valid,
	output logic                          release_is_store,
	output logic [ls_pkg::xlen-1:0]       release_addr,
	output logic [ls_pkg::xlen-1:0]       release_data,
	output logic [ls_pkg::tag_width-1:0]  release_tag
);

	import ls_pkg::*;

	// held operation
	logic                  held_valid;
	logic                  held_is_store;
	logic [xlen-1:0]       held_base;
	logic [imm_width-1:0]  held_imm;
	logic [xlen-1:0]       held_data;
	logic [tag_width-1:0]  held_tag;

	logic                  accept;
	logic                  store_blocked;

	// a store waits while the queue has no room
	assign store_blocked = held_is_store && sq_full;

	// loads go out in their first held cycle
	// squash kills the release in the same cycle
	assign release_valid = held_valid && !squash && !store_blocked;

	// slot can refill in the cycle it empties
	assign issue_ready = !held_valid || release_valid;

	assign accept = issue_valid && issue_ready;

	// effective address from base plus sign-extended offset
	assign release_addr     = held_base + sign_extend_imm(held_imm);
	assign release_is_store = held_is_store;
	assign release_data     = held_data;
	assign release_tag      = held_tag;

	// occupancy of the slot
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			held_valid <= 1'b0;
		end else if (squash) begin
			held_valid <= 1'b0;
		end else if (accept) begin
			held_valid <= 1'b1;
		end else if (release_valid) begin
			held_valid <= 1'b0;
		end
	end

	// operands only move on acceptance
	always_ff @(posedge clock) begin
		if (accept) begin
			held_is_store <= issue_is_store;
			held_base     <= issue_base;
			held_imm      <= issue_imm;
			held_data     <= issue_store_data;
			held_tag      <= issue_tag;
		end
	end

endmodule

`default_nettype wire

// File: store_queue/store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module store_queue (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     alloc,
	input  logic [ls_pkg::xlen-1:0]  alloc_addr,
	input  logic [ls_pkg::xlen-1:0]  alloc_data,
	input  logic                     lookup,
	input  logic [ls_pkg::xlen-1:0]  lookup_addr,
	input  logic                     commit,
	input  logic                     squash,
	output logic                     full,
	output logic                     fwd_hit,
	output logic [ls_pkg::xlen-1:0]  fwd_data,
	output logic                     drain_valid,
	output logic [ls_pkg::xlen-1:0]  drain_addr,
	output logic [ls_pkg::xlen-1:0]  drain_data
);

	import ls_pkg::*;

	// entry storage
	logic [sq_depth-1:0]       entry_valid;
	logic [xlen-1:0]           entry_addr [sq_depth];
	logic [xlen-1:0]           entry_data [sq_depth];

	// circular buffer bookkeeping
	logic [sq_idx_width-1:0]   head;
	logic [sq_idx_width-1:0]   tail;
	logic [sq_idx_width:0]     count;

	logic                      pop;
	logic [mem_idx_width-1:0]  lookup_word;
	logic                      scan_hit;
	logic [xlen-1:0]           scan_data;

	assign full = (count == sq_depth);

	// oldest store leaves on each commit pulse
	assign pop = commit && (count != '0);

	assign drain_valid = pop;
	assign drain_addr  = entry_addr[head];
	assign drain_data  = entry_data[head];

	assign lookup_word = lookup_addr[mem_idx_width+1:2];

	// walk back from the newest entry, first match is the youngest
	// the head being drained is still valid here, so it forwards too
	always_comb begin
		logic [sq_idx_width-1:0] idx;
		scan_hit  = 1'b0;
		scan_data = '0;
		idx       = tail;
		for (int i = 1; i <= sq_depth; i++) begin
			idx = tail - sq_idx_width'(i);
			if (!scan_hit && entry_valid[idx] &&
					entry_addr[idx][mem_idx_width+1:2] == lookup_word) begin
				scan_hit  = 1'b1;
				scan_data = entry_data[idx];
			end
		end
	end

	// pointers, count and valid bits
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head        <= '0;
			tail        <= '0;
			count       <= '0;
			entry_valid <= '0;
		end else if (squash) begin
			// drop every uncommitted store
			head        <= '0;
			tail        <= '0;
			count       <= '0;
			entry_valid <= '0;
		end else begin
			if (alloc) begin
				entry_valid[tail] <= 1'b1;
				tail              <= tail + 1'b1;
			end
			if (pop) begin
				entry_valid[head] <= 1'b0;
				head              <= head + 1'b1;
			end
			case ({alloc, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// address and data written at the tail
	always_ff @(posedge clock) begin
		if (alloc) begin
			entry_addr[tail] <= alloc_addr;
			entry_data[tail] <= alloc_data;
		end
	end

	// forwarding result, one cycle after the load release
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			fwd_hit <= 1'b0;
		end else begin
			fwd_hit <= lookup && scan_hit;
		end
	end

	always_ff @(posedge clock) begin
		if (lookup) begin
			fwd_data <= scan_data;
		end
	end

endmodule

`default_nettype wire

// File: logic/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic [ls_pkg::xlen-1:0]  read_addr,
	input  logic                     write_en,
	input  logic [ls_pkg::xlen-1:0]  write_addr,
	input  logic [ls_pkg::xlen-1:0]  write_data,
	output logic [ls_pkg::xlen-1:0]  read_data
);

	import ls_pkg::*;

	logic [xlen-1:0]           mem [mem_words];
	logic [mem_idx_width-1:0]  read_word;
	logic [mem_idx_width-1:0]  write_word;

	// word index only
	assign read_word  = read_addr[mem_idx_width+1:2];
	assign write_word = write_addr[mem_idx_width+1:2];

	// memory starts out all zero
	// a read at the write edge sees the old word
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < mem_words; i++) begin
				mem[i] <= '0;
			end
			read_data <= '0;
		end else begin
			if (write_en) begin
				mem[write_word] <= write_data;
			end
			read_data <= mem[read_word];
		end
	end

endmodule

`default_nettype wire

// File: logic/load_merge.sv
`timescale 1ns/1ps
`default_nettype none

module load_merge (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          release_valid,
	input  logic                          release_is_store,
	input  logic [ls_pkg::tag_width-1:0]  release_tag,
	input  logic                          fwd_hit,
	input  logic [ls_pkg::xlen-1:0]       fwd_data,
	input  logic [ls_pkg::xlen-1:0]       mem_data,
	output logic                          result_valid,
	output logic [ls_pkg::tag_width-1:0]  result_tag,
	output logic                          result_is_store,
	output logic [ls_pkg::xlen-1:0]       result_data
);

	import ls_pkg::*;

	// stage one travels beside the queue lookup and memory read
	logic                  s1_valid;
	logic                  s1_is_store;
	logic [tag_width-1:0]  s1_tag;
	logic [xlen-1:0]       merged;

	// store results carry no data
	assign merged = s1_is_store ? '0 : (fwd_hit ? fwd_data : mem_data);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid     <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			s1_valid     <= release_valid;
			result_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (release_valid) begin
			s1_is_store <= release_is_store;
			s1_tag      <= release_tag;
		end
		if (s1_valid) begin
			result_is_store <= s1_is_store;
			result_tag      <= s1_tag;
			result_data     <= merged;
		end
	end

endmodule

`default_nettype wire

// File: logic/ls_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module ls_unit_top (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          issue_valid,
	input  logic                          issue_is_store,
	input  logic [ls_pkg::xlen-1:0]       issue_base,
	input  logic [ls_pkg::imm_width-1:0]  issue_imm,
	input  logic [ls_pkg::xlen-1:0]       issue_store_data,
	input  logic [ls_pkg::tag_width-1:0]  issue_tag,
	input  logic                          commit,
	input  logic                          squash,
	output logic                          issue_ready,
	output logic                          result_valid,
	output logic [ls_pkg::tag_width-1:0]  result_tag,
	output logic                          result_is_store,
	output logic [ls_pkg::xlen-1:0]       result_data
);

	import ls_pkg::*;

	// slot to the parallel paths
	logic                  sq_full;
	logic                  release_valid;
	logic                  release_is_store;
	logic [xlen-1:0]       release_addr;
	logic [xlen-1:0]       release_data;
	logic [tag_width-1:0]  release_tag;

	// lookup results into the merge
	logic                  fwd_hit;
	logic [xlen-1:0]       fwd_data;
	logic [xlen-1:0]       mem_data;

	// committed store write into memory
	logic                  drain_valid;
	logic [xlen-1:0]       drain_addr;
	logic [xlen-1:0]       drain_data;

	ls_issue_slot u_ls_issue_slot (
		.clock            (clock),
		.rst_n            (rst_n),
		.issue_valid      (issue_valid),
		.issue_is_store   (issue_is_store),
		.issue_base       (issue_base),
		.issue_imm        (issue_imm),
		.issue_store_data (issue_store_data),
		.issue_tag        (issue_tag),
		.sq_full          (sq_full),
		.squash           (squash),
		.issue_ready      (issue_ready),
		.release_valid    (release_valid),
		.release_is_store (release_is_store),
		.release_addr     (release_addr),
		.release_data     (release_data),
		.release_tag      (release_tag)
	);

	// stores allocate, loads look up
	store_queue u_store_queue (
		.clock       (clock),
		.rst_n       (rst_n),
		.alloc       (release_valid && release_is_store),
		.alloc_addr  (release_addr),
		.alloc_data  (release_data),
		.lookup      (release_valid && !release_is_store),
		.lookup_addr (release_addr),
		.commit      (commit),
		.squash      (squash),
		.full        (sq_full),
		.fwd_hit     (fwd_hit),
		.fwd_data    (fwd_data),
		.drain_valid (drain_valid),
		.drain_addr  (drain_addr),
		.drain_data  (drain_data)
	);

	data_mem u_data_mem (
		.clock      (clock),
		.rst_n      (rst_n),
		.read_addr  (release_addr),
		.write_en   (drain_valid),
		.write_addr (drain_addr),
		.write_data (drain_data),
		.read_data  (mem_data)
	);

	load_merge u_load_merge (
		.clock            (clock),
		.rst_n            (rst_n),
		.release_valid    (release_valid),
		.release_is_store (release_is_store),
		.release_tag      (release_tag),
		.fwd_hit          (fwd_hit),
		.fwd_data         (fwd_data),
		.mem_data         (mem_data),
		.result_valid     (result_valid),
		.result_tag       (result_tag),
		.result_is_store  (result_is_store),
		.result_data      (result_data)
	);

endmodule

`default_nettype wire

// File: verification/ls_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ls_unit_assertions (
	input logic                          clock,
	input logic                          rst_n,
	input logic                          release_valid,
	input logic                          release_is_store,
	input logic [ls_pkg::tag_width-1:0]  release_tag,
	input logic                          sq_full,
	input logic                          result_valid,
	input logic [ls_pkg::tag_width-1:0]  result_tag,
	input logic [ls_pkg::sq_depth-1:0]   entry_valid
);

	import ls_pkg::*;

	// a store held against a full queue stays in the slot
	no_store_release_when_full: assert property (
		@(posedge clock) disable iff (!rst_n)
		(release_valid && release_is_store) |-> ($countones(entry_valid) < sq_depth)
	) else $error("store released while every store queue entry was valid");

	// a release always reaches the merge output with its own tag
	result_two_cycles_after_release: assert property (
		@(posedge clock) disable iff (!rst_n)
		release_valid |-> ##2 (result_valid && result_tag == $past(release_tag, 2))
	) else $error("no matching result two cycles after a release");

	full_needs_entries: assert property (
		@(posedge clock) disable iff (!rst_n)
		sq_full |-> (entry_valid != '0)
	) else $error("store queue full with no valid entry");

endmodule

bind ls_unit_top ls_unit_assertions u_ls_unit_assertions (
	.clock            (clock),
	.rst_n            (rst_n),
	.release_valid    (release_valid),
	.release_is_store (release_is_store),
	.release_tag      (release_tag),
	.sq_full          (sq_full),
	.result_valid     (result_valid),
	.result_tag       (result_tag),
	.entry_valid      (u_store_queue.entry_valid)
);

`default_nettype wire

// File: verification/ls_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ls_unit_tb;

	import ls_pkg::*;

	localparam int directed_ops = 35;
	localparam int random_ops = 400;
	localparam int cycle_limit = 4 * (directed_ops + random_ops) + 200;

	logic                  clock;
	logic                  rst_n;
	logic                  issue_valid;
	logic                  issue_is_store;
	logic [xlen-1:0]       issue_base;
	logic [imm_width-1:0]  issue_imm;
	logic [xlen-1:0]       issue_store_data;
	logic [tag_width-1:0]  issue_tag;
	logic                  commit;
	logic                  squash;
	logic                  issue_ready;
	logic                  result_valid;
	logic [tag_width-1:0]  result_tag;
	logic                  result_is_store;
	logic [xlen-1:0]       result_data;

	integer seed = 32'ha39c_a224;
	int checks = 0;
	int errors = 0;
	int base_checks = 0;
	int base_errors = 0;
	int cycle_count = 0;

	// reference model of slot, store queue and memory
	logic                  m_held = 1'b0;
	logic                  m_store;
	int                    m_word;
	logic [xlen-1:0]       m_data;
	logic [tag_width-1:0]  m_tag;
	logic [tag_width-1:0]  next_tag = '0;
	logic                  ready_seen;
	logic [xlen-1:0]       model_mem [mem_words];
	int                    mq_word [$];
	logic [xlen-1:0]       mq_data [$];

	// expected results in release order
	logic [tag_width-1:0]  exp_tag [$];
	logic                  exp_store [$];
	logic [xlen-1:0]       exp_data [$];

	ls_unit_top u_ls_unit_top (
		.clock            (clock),
		.rst_n            (rst_n),
		.issue_valid      (issue_valid),
		.issue_is_store   (issue_is_store),
		.issue_base       (issue_base),
		.issue_imm        (issue_imm),
		.issue_store_data (issue_store_data),
		.issue_tag        (issue_tag),
		.commit           (commit),
		.squash           (squash),
		.issue_ready      (issue_ready),
		.result_valid     (result_valid),
		.result_tag       (result_tag),
		.result_is_store  (result_is_store),
		.result_data      (result_data)
	);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: no progress after %0d cycles, results stopped arriving",
				cycle_limit);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [xlen-1:0] widen_imm(input logic [imm_width-1:0] imm);
		return {{(xlen - imm_width){imm[imm_width-1]}}, imm};
	endfunction

	task automatic check_value(input string what, input logic [xlen-1:0] got,
			input logic [xlen-1:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic check_result();
		if (result_valid) begin
			if (exp_tag.size() == 0) begin
				errors++;
				$display("result with tag %0d came out at %0t ns with nothing outstanding",
					result_tag, $time);
			end else begin
				check_value("result_tag", result_tag, exp_tag.pop_front());
				check_value("result_is_store", result_is_store, exp_store.pop_front());
				check_value("result_data", result_data, exp_data.pop_front());
			end
		end
	endtask

	// one clock edge of the model evaluated just before that edge
	task automatic model_step(input int word_in, output logic accepted);
		logic full;
		logic rel;
		logic ready;
		logic [xlen-1:0] value;
		int word;
		full = (mq_word.size() == sq_depth);
		rel = m_held && !squash && !(m_store && full);
		ready = !m_held || rel;
		ready_seen = issue_ready;
		check_value("issue_ready", issue_ready, ready);
		accepted = issue_valid && ready;
		word = m_word;
		if (rel) begin
			value = m_store ? '0 : model_mem[word];
			// later entries are younger so the last match wins
			for (int i = 0; i < mq_word.size(); i++) begin
				if (!m_store && mq_word[i] == word) begin
					value = mq_data[i];
				end
			end
			exp_tag.push_back(m_tag);
			exp_store.push_back(m_store);
			exp_data.push_back(value);
		end
		if (squash) begin
			mq_word.delete();
			mq_data.delete();
			m_held = 1'b0;
		end else begin
			if (commit && mq_word.size() != 0) begin
				model_mem[mq_word.pop_front()] = mq_data.pop_front();
			end
			if (rel && m_store) begin
				mq_word.push_back(word);
				mq_data.push_back(m_data);
			end
			if (accepted) begin
				m_held = 1'b1;
				m_store = issue_is_store;
				m_word = word_in;
				m_data = issue_store_data;
				m_tag = issue_tag;
				next_tag = next_tag + 1'b1;
			end else if (rel) begin
				m_held = 1'b0;
			end
		end
	endtask

	// random base and offset that land on the given word
	task automatic drive_cycle(input logic valid_in, input logic store_in, input int word,
			input logic [xlen-1:0] data_in, input logic commit_in, input logic squash_in,
			output logic accepted);
		logic [xlen-1:0] rnd;
		logic [xlen-1:0] target;
		@(negedge clock);
		check_result();
		rnd = $random(seed);
		target = ($random(seed) & 32'hffff_fc03) | (word << 2);
		issue_valid = valid_in;
		issue_is_store = store_in;
		issue_imm = rnd[imm_width-1:0];
		issue_base = target - widen_imm(rnd[imm_width-1:0]);
		issue_store_data = data_in;
		issue_tag = next_tag;
		commit = commit_in;
		squash = squash_in;
		#1;
		model_step(word, accepted);
	endtask

	task automatic issue_op(input logic store_in, input int word,
			input logic [xlen-1:0] data_in, input logic commit_in);
		logic accepted;
		accepted = 1'b0;
		while (!accepted) begin
			drive_cycle(1'b1, store_in, word, data_in, commit_in, 1'b0, accepted);
		end
	endtask

	task automatic wait_results();
		logic accepted;
		while (m_held || exp_tag.size() != 0) begin
			drive_cycle(1'b0, 1'b0, 0, '0, 1'b0, 1'b0, accepted);
		end
	endtask

	task automatic drain_queue();
		logic accepted;
		while (mq_word.size() != 0) begin
			drive_cycle(1'b0, 1'b0, 0, '0, 1'b1, 1'b0, accepted);
		end
		wait_results();
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d mismatches", name, checks - base_checks,
			errors - base_errors);
		base_checks = checks;
		base_errors = errors;
	endtask

	initial begin
		logic accepted;
		logic [xlen-1:0] rnd;
		clock = 1'b0;
		rst_n = 1'b0;
		issue_valid = 1'b0;
		issue_is_store = 1'b0;
		issue_base = '0;
		issue_imm = '0;
		issue_store_data = '0;
		issue_tag = '0;
		commit = 1'b0;
		squash = 1'b0;
		for (int i = 0; i < mem_words; i++) begin
			model_mem[i] = '0;
		end
		repeat (16) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		repeat (4) begin
			drive_cycle(1'b0, 1'b0, 0, '0, 1'b0, 1'b0, accepted);
		end
		check_value("issue_ready after reset", issue_ready, 1'b1);
		end_test("reset");

		// committed stores then loads with words 8 and 9 never written
		for (int w = 0; w < 4; w++) begin
			issue_op(1'b1, w, $random(seed), 1'b0);
		end
		drain_queue();
		for (int w = 0; w < 10; w++) begin
			if (w < 4 || w > 7) begin
				issue_op(1'b0, w, '0, 1'b0);
			end
		end
		wait_results();
		end_test("commit_then_load");

		issue_op(1'b1, 5, 32'h1111_0005, 1'b0);
		issue_op(1'b1, 5, 32'h2222_0005, 1'b0);
		issue_op(1'b0, 5, '0, 1'b0);
		drain_queue();
		issue_op(1'b1, 6, 32'h3333_0006, 1'b0);
		issue_op(1'b0, 6, '0, 1'b0);
		// load release meets the commit of its matching entry
		drive_cycle(1'b0, 1'b0, 0, '0, 1'b1, 1'b0, accepted);
		drain_queue();
		end_test("forwarding");

		// ninth store waits on a full queue
		for (int i = 0; i < 9; i++) begin
			issue_op(1'b1, i % 8, $random(seed), 1'b0);
		end
		drive_cycle(1'b0, 1'b0, 0, '0, 1'b0, 1'b0, accepted);
		check_value("issue_ready with full queue", ready_seen, 1'b0);
		issue_op(1'b0, 0, '0, 1'b1);
		issue_op(1'b0, 1, '0, 1'b0);
		drain_queue();
		end_test("back_pressure");

		issue_op(1'b1, 1, 32'h0000_0111, 1'b0);
		issue_op(1'b1, 2, 32'h0000_0222, 1'b0);
		drain_queue();
		issue_op(1'b1, 1, 32'h0000_0aaa, 1'b0);
		issue_op(1'b1, 2, 32'h0000_0bbb, 1'b0);
		issue_op(1'b0, 1, '0, 1'b0);
		issue_op(1'b1, 3, 32'h0000_0ccc, 1'b0);
		// store to word 3 is still in the slot here
		drive_cycle(1'b0, 1'b0, 0, '0, 1'b0, 1'b1, accepted);
		for (int w = 1; w < 4; w++) begin
			issue_op(1'b0, w, '0, 1'b0);
		end
		wait_results();
		end_test("squash");

		// about 2% squash and never together with commit or issue
		for (int n = 0; n < random_ops; n++) begin
			rnd = $random(seed);
			drive_cycle(rnd[9:8] != 2'b00 && rnd[7:0] >= 8'd5, rnd[10], rnd[15:12],
				$random(seed), rnd[11] && rnd[7:0] >= 8'd5, rnd[7:0] < 8'd5, accepted);
		end
		drain_queue();
		end_test("random");

		$display("summary: %0d checks, %0d mismatches", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
common/ls_pkg.sv
logic/ls_issue_slot.sv
store_queue/store_queue.sv
logic/data_mem.sv
logic/load_merge.sv
logic/ls_unit_top.sv
verification/ls_unit_assertions.sv
verification/ls_unit_tb.sv
